/* logic/ic_pkg.sv */
package ic_pkg;

  // thread and triangle sizing
  localparam int NUM_THREAD   = 32;
  localparam int BIT_THREAD   = $clog2(NUM_THREAD);
  localparam int NUM_TRIANGLE = 512;
  localparam int BIT_TRIANGLE = $clog2(NUM_TRIANGLE);

  // signed Q16.16 scalars
  localparam int COORD_W   = 32;
  localparam int FRAC_BITS = 16;

  // packed vector, x in the low word, then y, then z
  localparam int VEC_W = 3 * COORD_W;

  typedef enum logic {
    FETCH_IDLE,
    FETCH_RUN
  } fetch_state_t;

  typedef enum logic [1:0] {
    SEL_IDLE,
    SEL_SCAN,   // judging results of the current ray
    SEL_DONE    // one cycle, best is final
  } sel_state_t;

  typedef enum logic [1:0] {
    PNT_IDLE,
    PNT_MUL,    // products registered
    PNT_ADD     // result registered, result_valid high
  } pnt_state_t;

endpackage

/* logic/tri_fetch.sv */
`timescale 1ns/100ps

module tri_fetch import ic_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    ray_valid,
  input  logic [BIT_TRIANGLE:0]   tri_count,
  input  logic                    mem_rdy,
  output logic                    mem_en,
  output logic [BIT_TRIANGLE-1:0] triangle_id,
  output logic                    fetch_busy
);

  fetch_state_t            state;
  fetch_state_t            nxt_state;
  logic [BIT_TRIANGLE-1:0] id_cnt;
  logic [BIT_TRIANGLE:0]   count_r;   // triangles of the current ray
  logic                    accept;
  logic                    last_id;

  assign accept  = (state == FETCH_RUN) && mem_rdy;
  assign last_id = ({1'b0, id_cnt} == count_r - 1'b1);

  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      state <= FETCH_IDLE;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state = state;
    case (state)
      FETCH_IDLE: begin
        if (ray_valid)
          nxt_state = FETCH_RUN;
      end
      FETCH_RUN: begin
        if (accept && last_id)
          nxt_state = FETCH_IDLE;
      end
      default: nxt_state = FETCH_IDLE;
    endcase
  end

  // id only moves on an accepted cycle, so a stall holds it
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      id_cnt  <= '0;
      count_r <= '0;
    end else if (state == FETCH_IDLE && ray_valid) begin
      id_cnt  <= '0;
      count_r <= tri_count;
    end else if (accept) begin
      if (last_id)
        id_cnt <= '0;
      else
        id_cnt <= id_cnt + 1'b1;
    end
  end

  assign mem_en      = (state == FETCH_RUN);
  assign triangle_id = id_cnt;
  assign fetch_busy  = (state == FETCH_RUN);

endmodule

/* logic/hit_detect.sv */
`timescale 1ns/100ps

module hit_detect import ic_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    isect_valid,
  input  logic                    isect_last,
  input  logic [BIT_TRIANGLE-1:0] isect_tri_id,
  input  logic [COORD_W-1:0]      u,
  input  logic [COORD_W-1:0]      v,
  input  logic [COORD_W-1:0]      det,
  input  logic [COORD_W-1:0]      t,
  output logic                    d_valid,
  output logic                    d_last,
  output logic                    d_contact,
  output logic [BIT_TRIANGLE-1:0] d_tri_id,
  output logic [COORD_W-1:0]      d_t
);

  // one extra bit so u+v cannot wrap
  logic signed [COORD_W:0] u_ext;
  logic signed [COORD_W:0] v_ext;
  logic signed [COORD_W:0] det_ext;
  logic signed [COORD_W:0] uv_sum;
  logic                    contact;

  assign u_ext   = {u[COORD_W-1], u};
  assign v_ext   = {v[COORD_W-1], v};
  assign det_ext = {det[COORD_W-1], det};
  assign uv_sum  = u_ext + v_ext;

  assign contact = (det_ext > 0) &&
                   (u_ext >= 0) &&
                   (v_ext >= 0) &&
                   (uv_sum <= det_ext) &&
                   ($signed(t) > 0);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      d_valid   <= 1'b0;
      d_last    <= 1'b0;
      d_contact <= 1'b0;
      d_tri_id  <= '0;
      d_t       <= '0;
    end else begin
      d_valid <= isect_valid;
      d_last  <= isect_valid && isect_last;
      if (isect_valid) begin
        d_contact <= contact;
        d_tri_id  <= isect_tri_id;
        d_t       <= t;
      end
    end
  end

endmodule

/* logic/hit_select.sv */
`timescale 1ns/100ps

module hit_select import ic_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    ray_valid,
  input  logic                    d_valid,
  input  logic                    d_last,
  input  logic                    d_contact,
  input  logic [BIT_TRIANGLE-1:0] d_tri_id,
  input  logic [COORD_W-1:0]      d_t,
  output logic                    sel_done,
  output logic                    sel_hit,
  output logic [BIT_TRIANGLE-1:0] sel_tri_id,
  output logic [COORD_W-1:0]      sel_t
);

  sel_state_t state;
  sel_state_t nxt_state;
  logic       closer;  // d_t strictly below the stored best
  logic       take;

  // fixed-point less-than, ties keep the earlier contact
  assign closer = ($signed(d_t) < $signed(sel_t));
  assign take   = (state == SEL_SCAN) && d_valid && d_contact && (!sel_hit || closer);

  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      state <= SEL_IDLE;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state = state;
    case (state)
      SEL_IDLE: begin
        if (ray_valid)
          nxt_state = SEL_SCAN;
      end
      SEL_SCAN: begin
        if (d_valid && d_last)
          nxt_state = SEL_DONE;
      end
      SEL_DONE: begin
        nxt_state = SEL_IDLE;
      end
      default: nxt_state = SEL_IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sel_hit    <= 1'b0;
      sel_tri_id <= '0;
      sel_t      <= '0;
    end else if (state == SEL_IDLE && ray_valid) begin
      sel_hit    <= 1'b0;  // fresh ray, forget the last best
      sel_tri_id <= '0;
      sel_t      <= '0;
    end else if (take) begin
      sel_hit    <= 1'b1;
      sel_tri_id <= d_tri_id;
      sel_t      <= d_t;
    end
  end

  // best registers hold still from here until the next ray
  assign sel_done = (state == SEL_DONE);

endmodule

/* logic/hit_point.sv */
`timescale 1ns/100ps

module hit_point import ic_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    ray_valid,
  input  logic [BIT_THREAD-1:0]   ray_id,
  input  logic [VEC_W-1:0]        orig,
  input  logic [VEC_W-1:0]        dir,
  input  logic                    sel_done,
  input  logic                    sel_hit,
  input  logic [BIT_TRIANGLE-1:0] sel_tri_id,
  input  logic [COORD_W-1:0]      sel_t,
  output logic                    result_valid,
  output logic                    result_hit,
  output logic [BIT_THREAD-1:0]   result_ray_id,
  output logic [BIT_TRIANGLE-1:0] result_tri_id,
  output logic [COORD_W-1:0]      result_t,
  output logic [VEC_W-1:0]        result_point,
  output logic                    point_busy
);

  pnt_state_t                  state;
  pnt_state_t                  nxt_state;
  logic [BIT_THREAD-1:0]       ray_id_r;
  logic [VEC_W-1:0]            orig_r;
  logic [VEC_W-1:0]            dir_r;
  logic signed [2*COORD_W-1:0] prod [3];    // t * dir per component
  logic signed [2*COORD_W-1:0] scaled [3];
  logic [VEC_W-1:0]            point_sum;

  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      state <= PNT_IDLE;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state = state;
    case (state)
      PNT_IDLE: begin
        if (sel_done)
          nxt_state = PNT_MUL;
      end
      PNT_MUL: nxt_state = PNT_ADD;
      PNT_ADD: nxt_state = PNT_IDLE;
      default: nxt_state = PNT_IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      point_busy <= 1'b0;
      ray_id_r   <= '0;
      orig_r     <= '0;
      dir_r      <= '0;
    end else if (ray_valid && !point_busy) begin
      point_busy <= 1'b1;
      ray_id_r   <= ray_id;
      orig_r     <= orig;
      dir_r      <= dir;
    end else if (state == PNT_ADD) begin
      point_busy <= 1'b0;   // drops after the result cycle
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int k = 0; k < 3; k++)
        prod[k] <= '0;
    end else if (state == PNT_IDLE && sel_done) begin
      for (int k = 0; k < 3; k++)
        prod[k] <= $signed(dir_r[k*COORD_W +: COORD_W]) * $signed(sel_t);
    end
  end

  // rescale to Q16.16, keep low word, wraps on overflow
  always_comb begin
    for (int k = 0; k < 3; k++) begin
      scaled[k] = prod[k] >>> FRAC_BITS;
      point_sum[k*COORD_W +: COORD_W] = orig_r[k*COORD_W +: COORD_W]
                                        + scaled[k][COORD_W-1:0];
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      result_hit    <= 1'b0;
      result_ray_id <= '0;
      result_tri_id <= '0;
      result_t      <= '0;
      result_point  <= '0;
    end else if (state == PNT_MUL) begin
      result_hit    <= sel_hit;
      result_ray_id <= ray_id_r;
      result_tri_id <= sel_hit ? sel_tri_id : '0;   // miss reports zeros
      result_t      <= sel_hit ? sel_t : '0;
      result_point  <= sel_hit ? point_sum : '0;
    end
  end

  assign result_valid = (state == PNT_ADD);

endmodule

/* logic/ic_controller.sv */
`timescale 1ns/100ps

module ic_controller import ic_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    ray_valid,
  input  logic [BIT_THREAD-1:0]   ray_id,
  input  logic [VEC_W-1:0]        orig,
  input  logic [VEC_W-1:0]        dir,
  input  logic [BIT_TRIANGLE:0]   tri_count,
  input  logic                    mem_rdy,
  output logic                    mem_en,
  output logic [BIT_TRIANGLE-1:0] triangle_id,
  input  logic                    isect_valid,
  input  logic                    isect_last,
  input  logic [BIT_TRIANGLE-1:0] isect_tri_id,
  input  logic [COORD_W-1:0]      u,
  input  logic [COORD_W-1:0]      v,
  input  logic [COORD_W-1:0]      det,
  input  logic [COORD_W-1:0]      t,
  output logic                    ray_busy,
  output logic                    result_valid,
  output logic                    result_hit,
  output logic [BIT_THREAD-1:0]   result_ray_id,
  output logic [BIT_TRIANGLE-1:0] result_tri_id,
  output logic [COORD_W-1:0]      result_t,
  output logic [VEC_W-1:0]        result_point
);

  logic                    fetch_busy;
  logic                    point_busy;
  logic                    d_valid;
  logic                    d_last;
  logic                    d_contact;
  logic [BIT_TRIANGLE-1:0] d_tri_id;
  logic [COORD_W-1:0]      d_t;
  logic                    sel_done;
  logic                    sel_hit;
  logic [BIT_TRIANGLE-1:0] sel_tri_id;
  logic [COORD_W-1:0]      sel_t;

  assign ray_busy = fetch_busy | point_busy;   // point stage covers the tail

  tri_fetch u_fetch (
    .clk(clk), .rst(rst), .ray_valid(ray_valid), .tri_count(tri_count),
    .mem_rdy(mem_rdy), .mem_en(mem_en), .triangle_id(triangle_id),
    .fetch_busy(fetch_busy)
  );

  hit_detect u_detect (
    .clk(clk), .rst(rst), .isect_valid(isect_valid), .isect_last(isect_last),
    .isect_tri_id(isect_tri_id), .u(u), .v(v), .det(det), .t(t),
    .d_valid(d_valid), .d_last(d_last), .d_contact(d_contact),
    .d_tri_id(d_tri_id), .d_t(d_t)
  );

  hit_select u_select (
    .clk(clk), .rst(rst), .ray_valid(ray_valid),
    .d_valid(d_valid), .d_last(d_last), .d_contact(d_contact),
    .d_tri_id(d_tri_id), .d_t(d_t),
    .sel_done(sel_done), .sel_hit(sel_hit), .sel_tri_id(sel_tri_id), .sel_t(sel_t)
  );

  hit_point u_point (
    .clk(clk), .rst(rst), .ray_valid(ray_valid), .ray_id(ray_id),
    .orig(orig), .dir(dir),
    .sel_done(sel_done), .sel_hit(sel_hit), .sel_tri_id(sel_tri_id), .sel_t(sel_t),
    .result_valid(result_valid), .result_hit(result_hit),
    .result_ray_id(result_ray_id), .result_tri_id(result_tri_id),
    .result_t(result_t), .result_point(result_point), .point_busy(point_busy)
  );

endmodule

/* sim/ic_controller_checker.sv */
`timescale 1ns/100ps

module ic_controller_checker import ic_pkg::*; (
  input logic                    clk,
  input logic                    rst,
  input logic                    ray_valid,
  input logic                    ray_busy,
  input logic                    mem_en,
  input logic                    mem_rdy,
  input logic [BIT_TRIANGLE-1:0] triangle_id,
  input logic                    isect_valid,
  input logic                    isect_last,
  input logic                    result_valid
);

  int unsigned pulse_fails = 0;
  int unsigned hold_fails = 0;
  int unsigned busy_fails = 0;
  int unsigned latency_fails = 0;
  int unsigned fail_count;

  assign fail_count = pulse_fails + hold_fails + busy_fails + latency_fails;

  result_pulse: assert property (@(posedge clk) disable iff (rst)
    result_valid |=> !result_valid)
    else begin
      $error("result_valid stayed high for more than one cycle");
      pulse_fails++;
    end

  // a stalled request must not move
  stall_hold: assert property (@(posedge clk) disable iff (rst)
    (mem_en && !mem_rdy) |=> (mem_en && $stable(triangle_id)))
    else begin
      $error("mem_en or triangle_id changed while memory stalled");
      hold_fails++;
    end

  // fetching only continues a request or follows an accepted ray
  fetch_in_ray: assert property (@(posedge clk) disable iff (rst)
    mem_en |-> (ray_busy && $past(mem_en || (ray_valid && !ray_busy))))
    else begin
      $error("mem_en high outside an accepted ray");
      busy_fails++;
    end

  result_latency: assert property (@(posedge clk) disable iff (rst)
    (isect_valid && isect_last) |-> ##4 result_valid)
    else begin
      $error("result_valid missing 4 cycles after the last result");
      latency_fails++;
    end

endmodule

bind ic_controller ic_controller_checker u_checker (
  .clk(clk), .rst(rst), .ray_valid(ray_valid), .ray_busy(ray_busy), .mem_en(mem_en),
  .mem_rdy(mem_rdy), .triangle_id(triangle_id), .isect_valid(isect_valid),
  .isect_last(isect_last), .result_valid(result_valid)
);

/* sim/ic_controller_tb.sv */
`timescale 1ns/100ps

module ic_controller_tb import ic_pkg::*; ();

  logic                    clk;
  logic                    rst;
  logic                    ray_valid;
  logic [BIT_THREAD-1:0]   ray_id;
  logic [VEC_W-1:0]        orig;
  logic [VEC_W-1:0]        dir;
  logic [BIT_TRIANGLE:0]   tri_count;
  logic                    mem_rdy;
  logic                    mem_en;
  logic [BIT_TRIANGLE-1:0] triangle_id;
  logic                    isect_valid;
  logic                    isect_last;
  logic [BIT_TRIANGLE-1:0] isect_tri_id;
  logic [COORD_W-1:0]      u;
  logic [COORD_W-1:0]      v;
  logic [COORD_W-1:0]      det;
  logic [COORD_W-1:0]      t;
  logic                    ray_busy;
  logic                    result_valid;
  logic                    result_hit;
  logic [BIT_THREAD-1:0]   result_ray_id;
  logic [BIT_TRIANGLE-1:0] result_tri_id;
  logic [COORD_W-1:0]      result_t;
  logic [VEC_W-1:0]        result_point;

  logic [31:0]      fld [8];      // fields of the trace line just read
  logic [31:0]      r_id;
  logic [31:0]      r_cnt;
  logic [31:0]      r_orig [3];
  logic [31:0]      r_dir [3];
  logic [31:0]      res [64][6];  // tri, u, v, det, t, last
  int               n_res;
  logic [31:0]      e_hit;
  logic [31:0]      e_tri;
  logic [31:0]      e_t;
  logic [31:0]      e_point [3];
  logic [31:0]      lfsr;
  int               test_errors;
  int               n_pass;
  int               n_fail;
  int               n_lines;
  int               wd_cycles;
  int               fd;
  int               code;
  logic [7:0]       tag;
  logic [8*256-1:0] line_buf;
  bit               reading;

  ic_controller uut (.*);

  always #50 clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    else
      return s >> 1;
  endfunction

  function automatic bit is_contact(input logic [31:0] cu, input logic [31:0] cv,
                                    input logic [31:0] cdet, input logic [31:0] ct);
    longint su;
    longint sv;
    longint sd;
    su = longint'($signed(cu));
    sv = longint'($signed(cv));
    sd = longint'($signed(cdet));
    return (sd > 0) && (su >= 0) && (sv >= 0) && (su + sv <= sd) && ($signed(ct) > 0);
  endfunction

  // origin plus t times direction, Q16.16, low word kept
  function automatic logic [31:0] point_component(input logic [31:0] o, input logic [31:0] d,
                                                  input logic [31:0] tt);
    longint prod;
    longint scaled;
    prod = longint'($signed(d)) * longint'($signed(tt));
    scaled = prod >>> FRAC_BITS;
    return o + scaled[31:0];
  endfunction

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    assert (actual === expected)
      else begin
        $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        test_errors++;
      end
  endtask

  task automatic require(input bit cond, input string what);
    assert (cond)
      else begin
        $display("ERROR at %0t ns: %s", $time, what);
        test_errors++;
      end
  endtask

  task automatic tick();
    @(posedge clk);
    #5;
  endtask

  task automatic read_fields(input int n);
    logic [31:0] val;
    int          got;
    for (int k = 0; k < n; k++) begin
      got = $fscanf(fd, " %h", val);
      require(got == 1, "malformed line in the trace file");
      fld[k] = val;
    end
  endtask

  task automatic predict_outcome();
    bit          hit;
    logic [31:0] best_tri;
    logic [31:0] best_t;
    logic [31:0] pt;
    hit = 1'b0;
    best_tri = '0;
    best_t = '0;
    for (int k = 0; k < n_res; k++) begin
      if (is_contact(res[k][1], res[k][2], res[k][3], res[k][4]) &&
          (!hit || $signed(res[k][4]) < $signed(best_t))) begin
        hit = 1'b1;
        best_tri = res[k][0];
        best_t = res[k][4];
      end
    end
    require(e_hit == 32'(hit) && e_tri == best_tri && e_t == best_t,
            "expected hit, tri id or t in the trace breaks the contact or nearest rule");
    for (int c = 0; c < 3; c++) begin
      pt = hit ? point_component(r_orig[c], r_dir[c], best_t) : 32'd0;
      require(pt == e_point[c], "expected point in the trace breaks the point rule");
    end
  endtask

  task automatic send_ray();
    ray_valid = 1'b1;
    ray_id    = r_id[BIT_THREAD-1:0];
    orig      = {r_orig[2], r_orig[1], r_orig[0]};
    dir       = {r_dir[2], r_dir[1], r_dir[0]};
    tri_count = r_cnt[BIT_TRIANGLE:0];
    tick();
    ray_valid = 1'b0;
    require(ray_busy, "ray_busy did not rise after ray_valid");
    require(mem_en, "mem_en did not rise in the cycle after ray_valid");
  endtask

  // random back-pressure, one lfsr bit per cycle
  task automatic run_fetch();
    int accepted;
    accepted = 0;
    while (mem_en) begin
      lfsr = lfsr_next(lfsr);
      mem_rdy = lfsr[0];
      if (mem_rdy) begin
        compare_value("triangle_id", 32'(accepted), 32'(triangle_id));
        accepted++;
      end
      tick();
    end
    mem_rdy = 1'b0;
    compare_value("accepted id count", r_cnt, 32'(accepted));
  endtask

  task automatic send_results();
    for (int k = 0; k < n_res; k++) begin
      isect_valid  = 1'b1;
      isect_last   = res[k][5][0];
      isect_tri_id = res[k][0][BIT_TRIANGLE-1:0];
      u            = res[k][1];
      v            = res[k][2];
      det          = res[k][3];
      t            = res[k][4];
      tick();
    end
    isect_valid = 1'b0;
    isect_last  = 1'b0;
  endtask

  task automatic run_ray();
    int lat;
    predict_outcome();
    send_ray();
    run_fetch();
    send_results();
    lat = 1;   // one cycle already passed since the last result
    while (!result_valid && lat < 16) begin
      tick();
      lat++;
    end
    require(result_valid, "result_valid did not arrive within 16 cycles");
    compare_value("result latency", 32'd4, 32'(lat));
    compare_value("result_hit", e_hit, 32'(result_hit));
    compare_value("result_ray_id", r_id, 32'(result_ray_id));
    compare_value("result_tri_id", e_tri, 32'(result_tri_id));
    compare_value("result_t", e_t, result_t);
    for (int c = 0; c < 3; c++)
      compare_value($sformatf("result_point[%0d]", c), e_point[c],
                    result_point[c*COORD_W +: COORD_W]);
    while (ray_busy)
      tick();
    $display("ray id %0d, %0d results: %s (%0d errors)", r_id, n_res,
             (test_errors == 0) ? "pass" : "FAIL", test_errors);
    if (test_errors == 0)
      n_pass++;
    else
      n_fail++;
    test_errors = 0;
  endtask

  // watchdog, 40 cycles per trace line
  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk);
    $display("watchdog: simulation timed out after %0d cycles", wd_cycles);
    $display("Test failed");
    $finish;
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    ray_valid = 1'b0;
    ray_id = '0;
    orig = '0;
    dir = '0;
    tri_count = '0;
    mem_rdy = 1'b0;
    isect_valid = 1'b0;
    isect_last = 1'b0;
    isect_tri_id = '0;
    u = '0;
    v = '0;
    det = '0;
    t = '0;
    lfsr = 32'd88873;
    test_errors = 0;
    n_pass = 0;
    n_fail = 0;
    n_lines = 0;
    n_res = 0;
    wd_cycles = 0;
    fd = $fopen("sim/ic_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file sim/ic_trace.txt");
      n_fail++;
    end else begin
      while ($fgets(line_buf, fd) != 0)
        n_lines++;
      $fclose(fd);
      fd = $fopen("sim/ic_trace.txt", "r");
      wd_cycles = n_lines * 40;
    end
    repeat (2) @(posedge clk);
    #5;
    rst = 1'b0;
    reading = (fd != 0);
    while (reading) begin
      code = $fscanf(fd, " %c", tag);
      if (code != 1) begin
        reading = 1'b0;
      end else if (tag == "#") begin
        code = $fgets(line_buf, fd);   // column notes
      end else if (tag == "R") begin
        read_fields(8);
        r_id = fld[0];
        for (int c = 0; c < 3; c++) begin
          r_orig[c] = fld[1+c];
          r_dir[c] = fld[4+c];
        end
        r_cnt = fld[7];
        n_res = 0;
      end else if (tag == "I") begin
        read_fields(6);
        require(n_res < 64, "more than 64 results for one ray in the trace");
        if (n_res < 64) begin
          for (int f = 0; f < 6; f++)
            res[n_res][f] = fld[f];
          n_res++;
        end
      end else if (tag == "E") begin
        read_fields(6);
        e_hit = fld[0];
        e_tri = fld[1];
        e_t = fld[2];
        for (int c = 0; c < 3; c++)
          e_point[c] = fld[3+c];
        run_ray();
      end else begin
        $display("unknown line tag '%c' in the trace file", tag);
        n_fail++;
        reading = 1'b0;
      end
    end
    if (fd != 0)
      $fclose(fd);
    if (test_errors != 0)
      n_fail++;   // trailing lines without an E line
    if (uut.u_checker.fail_count != 0) begin
      $display("bound checker reported %0d assertion failures", uut.u_checker.fail_count);
      n_fail++;
    end
    if (n_pass == 0)
      $display("no ray was tested");
    $display("tests: %0d passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0 && n_pass > 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

/* vlog.f */
logic/ic_pkg.sv
logic/tri_fetch.sv
logic/hit_detect.sv
logic/hit_select.sv
logic/hit_point.sv
logic/ic_controller.sv
sim/ic_controller_checker.sv
sim/ic_controller_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the ic_controller testbench with Verilator, runs it and scans the log
set -euo pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module ic_controller_tb \
  -f vlog.f

# error limit raised so assertion failures reach the final report
./obj_dir/Vic_controller_tb +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "Test failed" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation finished without failures"

/* sim/ic_trace.txt */
# R ray_id orig_x orig_y orig_z dir_x dir_y dir_z tri_count  |  I tri_id u v det t last
# E hit tri_id t point_x point_y point_z  (all hex, Q16.16 for coordinates)
R 03 00010000 00020000 00030000 00008000 FFFF0000 00020000 004
I 000 00004000 00004000 00010000 00030000 0
I 001 00004000 00004000 00010000 00020000 0
I 002 00004000 00004000 00010000 00020000 0
I 003 00004000 00004000 00010000 00050000 1
E 1 001 00020000 00020000 00000000 00070000
R 0A 00050000 00050000 00050000 00010000 00010000 00010000 005
I 000 00000000 00000000 00000000 00010000 0
I 001 00000000 00000000 FFFF0000 00010000 0
I 002 FFFFC000 00004000 00010000 00010000 0
I 003 00008000 00008001 00010000 00010000 0
I 004 00000000 00000000 00010000 00000000 1
E 0 000 00000000 00000000 00000000 00000000
R 11 FFFF0000 00000000 00008000 FFFE0000 00004000 FFFF8000 004
I 000 00000000 00000000 00000001 FFFF0000 0
I 001 00008000 00008000 00010000 00018000 0
I 002 00000000 00000000 00000001 00000001 0
I 003 7FFFFFFF 7FFFFFFF 7FFFFFFF 00000002 1
E 1 002 00000001 FFFEFFFE 00000000 00007FFF
R 1F 7FFF0000 00000000 80000000 00010000 7FFFFFFF FFFFFFFF 002
I 000 00000000 00000000 00010000 00020000 0
I 001 00000000 00000000 00010000 00030000 1
E 1 000 00020000 80010000 FFFFFFFE 7FFFFFFE
R 00 00000000 00000000 00000000 00030000 FFFD0000 00000000 001
I 000 00002000 00001000 00008000 00018000 1
E 1 000 00018000 00048000 FFFB8000 00000000
R 05 00010000 00010000 00010000 00000000 00000000 00000000 003
I 000 00000000 FFFFFFFF 00010000 00010000 0
I 001 00000000 00000000 80000000 00000001 0
I 002 00010000 00000000 00010000 80000000 1
E 0 000 00000000 00000000 00000000 00000000
